//--- common/exu_pkg.sv
`default_nettype none

package exu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [4:0]      reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_SLE  = 4'd10,
    ALU_SLEU = 4'd11
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_ALU    = 3'd0,
    CLS_BRANCH = 3'd1,
    CLS_JUMP   = 3'd2,
    CLS_LOAD   = 3'd3,
    CLS_STORE  = 3'd4,
    CLS_SYSTEM = 3'd5
  } op_class_e;

  typedef enum logic [3:0] {
    SYS_CSRRW  = 4'd0,
    SYS_CSRRS  = 4'd1,
    SYS_CSRRC  = 4'd2,
    SYS_CSRRWI = 4'd3,
    SYS_CSRRSI = 4'd4,
    SYS_CSRRCI = 4'd5,
    SYS_ECALL  = 4'd6,
    SYS_EBREAK = 4'd7,
    SYS_MRET   = 4'd8
  } sys_op_e;

  typedef enum logic [1:0] {
    EXU_IDLE = 2'd0,
    EXU_BUSY = 2'd1,
    EXU_HOLD = 2'd2
  } exu_state_e;

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam word_t CAUSE_ECALL_M = 32'd11;
  // mpp resets to machine mode.
  localparam word_t MSTATUS_RESET = 32'h0000_1800;
  localparam word_t MTVEC_RESET   = 32'h0000_0000;

endpackage

`default_nettype wire

//--- common/exu_mem_if.sv
`default_nettype none

interface exu_mem_if;

  logic          req;
  logic          we;
  exu_pkg::word_t addr;
  exu_pkg::word_t wdata;
  exu_pkg::word_t rdata;
  logic          done;

  modport master (
    output req, we, addr, wdata,
    input  rdata, done
  );

  modport slave (
    input  req, we, addr, wdata,
    output rdata, done
  );

endinterface

`default_nettype wire

//--- verilog/exu_alu.sv
`default_nettype none

module exu_alu (
  input  exu_pkg::alu_op_e op_i,
  input  exu_pkg::word_t   a_i,
  input  exu_pkg::word_t   b_i,
  output exu_pkg::word_t   res_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    res_o = '0;
    case (op_i)
      exu_pkg::ALU_ADD:  res_o = a_i + b_i;
      exu_pkg::ALU_SUB:  res_o = a_i - b_i;
      exu_pkg::ALU_AND:  res_o = a_i & b_i;
      exu_pkg::ALU_OR:   res_o = a_i | b_i;
      exu_pkg::ALU_XOR:  res_o = a_i ^ b_i;
      exu_pkg::ALU_SLL:  res_o = a_i << shamt;
      exu_pkg::ALU_SRL:  res_o = a_i >> shamt;
      exu_pkg::ALU_SRA:  res_o = $signed(a_i) >>> shamt;
      // compares give 1 or 0, branches test the result against zero.
      exu_pkg::ALU_SLT:  res_o = {31'd0, $signed(a_i) < $signed(b_i)};
      exu_pkg::ALU_SLTU: res_o = {31'd0, a_i < b_i};
      exu_pkg::ALU_SLE:  res_o = {31'd0, $signed(a_i) <= $signed(b_i)};
      exu_pkg::ALU_SLEU: res_o = {31'd0, a_i <= b_i};
      default:           res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- exu/exu_csr_file.sv
`default_nettype none

module exu_csr_file (
  input  logic                clk,
  input  logic                rst,
  input  exu_pkg::csr_addr_t  raddr_i,
  output exu_pkg::word_t      rdata_o,
  input  logic                we_i,
  input  exu_pkg::csr_addr_t  waddr_i,
  input  exu_pkg::word_t      wdata_i,
  input  logic                trap_we_i,
  input  exu_pkg::word_t      trap_epc_i,
  output exu_pkg::word_t      mtvec_o,
  output exu_pkg::word_t      mepc_o
);

  exu_pkg::word_t mstatus;
  exu_pkg::word_t mtvec;
  exu_pkg::word_t mepc;
  exu_pkg::word_t mcause;

  always_comb begin
    case (raddr_i)
      exu_pkg::CSR_MSTATUS: rdata_o = mstatus;
      exu_pkg::CSR_MTVEC:   rdata_o = mtvec;
      exu_pkg::CSR_MEPC:    rdata_o = mepc;
      exu_pkg::CSR_MCAUSE:  rdata_o = mcause;
      default:              rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= exu_pkg::MSTATUS_RESET;
      mtvec   <= exu_pkg::MTVEC_RESET;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (we_i) begin
        case (waddr_i)
          exu_pkg::CSR_MSTATUS: mstatus <= wdata_i;
          exu_pkg::CSR_MTVEC:   mtvec   <= wdata_i;
          exu_pkg::CSR_MEPC:    mepc    <= wdata_i;
          exu_pkg::CSR_MCAUSE:  mcause  <= wdata_i;
          default:              ;
        endcase
      end
      // trap entry wins over the general port.
      if (trap_we_i) begin
        mepc   <= trap_epc_i;
        mcause <= exu_pkg::CAUSE_ECALL_M;
      end
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

`default_nettype wire

//--- exu/exu_stage.sv
`default_nettype none

module exu_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  exu_pkg::op_class_e  class_i,
  input  exu_pkg::alu_op_e    alu_op_i,
  input  exu_pkg::sys_op_e    sys_op_i,
  input  exu_pkg::word_t      src1_i,
  input  exu_pkg::word_t      src2_i,
  input  exu_pkg::word_t      target_i,
  input  exu_pkg::csr_addr_t  csr_addr_i,
  input  exu_pkg::reg_idx_t   rd_i,
  input  exu_pkg::word_t      pc_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                wb_en_o,
  output exu_pkg::reg_idx_t   rd_o,
  output exu_pkg::word_t      wb_data_o,
  output exu_pkg::word_t      npc_o,
  output logic                ebreak_o,
  exu_mem_if.master           mem
);

  exu_pkg::exu_state_e state;
  logic                first_q;

  exu_pkg::op_class_e  class_q;
  exu_pkg::alu_op_e    alu_op_q;
  exu_pkg::sys_op_e    sys_op_q;
  exu_pkg::word_t      src1_q;
  exu_pkg::word_t      src2_q;
  exu_pkg::word_t      target_q;
  exu_pkg::csr_addr_t  csr_addr_q;
  exu_pkg::word_t      pc_q;

  exu_pkg::word_t      alu_res;
  exu_pkg::word_t      pc_plus4;
  logic                taken;
  logic                is_sys;

  exu_pkg::csr_addr_t  csr_addr;
  exu_pkg::word_t      csr_rdata;
  exu_pkg::word_t      csr_old_q;
  exu_pkg::word_t      csr_old;
  exu_pkg::word_t      csr_wdata;
  logic                csr_we;
  logic                trap_we;
  exu_pkg::word_t      mtvec;
  exu_pkg::word_t      mepc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= exu_pkg::EXU_IDLE;
      first_q <= 1'b0;
    end else begin
      first_q <= 1'b0;
      case (state)
        exu_pkg::EXU_IDLE: begin
          if (in_valid_i) begin
            if (class_i == exu_pkg::CLS_LOAD || class_i == exu_pkg::CLS_STORE) begin
              state <= exu_pkg::EXU_BUSY;
            end else begin
              state   <= exu_pkg::EXU_HOLD;
              first_q <= 1'b1;
            end
          end
        end
        exu_pkg::EXU_BUSY: begin
          if (mem.done) begin
            state   <= exu_pkg::EXU_HOLD;
            first_q <= 1'b1;
          end
        end
        exu_pkg::EXU_HOLD: begin
          if (out_ready_i) begin
            state <= exu_pkg::EXU_IDLE;
          end
        end
        default: state <= exu_pkg::EXU_IDLE;
      endcase
    end
  end

  // instruction register.
  always_ff @(posedge clk) begin
    if (in_ready_o && in_valid_i) begin
      class_q    <= class_i;
      alu_op_q   <= alu_op_i;
      sys_op_q   <= sys_op_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      target_q   <= target_i;
      csr_addr_q <= csr_addr_i;
      rd_o       <= rd_i;
      pc_q       <= pc_i;
    end
  end

  assign in_ready_o  = (state == exu_pkg::EXU_IDLE);
  assign out_valid_o = (state == exu_pkg::EXU_HOLD);
  assign wb_en_o     = first_q;

  exu_alu alu_i (
    .op_i  (alu_op_q),
    .a_i   (src1_q),
    .b_i   (src2_q),
    .res_o (alu_res)
  );

  assign pc_plus4 = pc_q + 32'd4;
  assign is_sys   = (class_q == exu_pkg::CLS_SYSTEM);

  always_comb begin
    case (alu_op_q)
      exu_pkg::ALU_SUB:  taken = (alu_res == '0);
      exu_pkg::ALU_XOR,
      exu_pkg::ALU_SLT,
      exu_pkg::ALU_SLTU,
      exu_pkg::ALU_SLE,
      exu_pkg::ALU_SLEU: taken = (alu_res != '0);
      default:           taken = 1'b0;
    endcase
  end

  always_comb begin
    npc_o = pc_plus4;
    case (class_q)
      exu_pkg::CLS_BRANCH: npc_o = taken ? target_q : pc_plus4;
      exu_pkg::CLS_JUMP:   npc_o = target_q;
      exu_pkg::CLS_SYSTEM: begin
        if (sys_op_q == exu_pkg::SYS_ECALL) begin
          npc_o = mtvec;
        end else if (sys_op_q == exu_pkg::SYS_MRET) begin
          npc_o = mepc;
        end
      end
      default: npc_o = pc_plus4;
    endcase
  end

  // ecall and mret reach their CSR through the general port.
  always_comb begin
    case (sys_op_q)
      exu_pkg::SYS_ECALL: csr_addr = exu_pkg::CSR_MCAUSE;
      exu_pkg::SYS_MRET:  csr_addr = exu_pkg::CSR_MSTATUS;
      default:            csr_addr = csr_addr_q;
    endcase
  end

  always_comb begin
    csr_wdata = src1_q;
    case (sys_op_q)
      exu_pkg::SYS_CSRRS,
      exu_pkg::SYS_CSRRSI: csr_wdata = csr_rdata | src1_q;
      exu_pkg::SYS_CSRRC,
      exu_pkg::SYS_CSRRCI: csr_wdata = csr_rdata & ~src1_q;
      exu_pkg::SYS_ECALL:  csr_wdata = exu_pkg::CAUSE_ECALL_M;
      // mie takes mpie, mpie is set.
      exu_pkg::SYS_MRET:   csr_wdata = {csr_rdata[31:8], 1'b1, csr_rdata[6:4],
                                        csr_rdata[7], csr_rdata[2:0]};
      default:             csr_wdata = src1_q;
    endcase
  end

  assign csr_we  = first_q && is_sys && (sys_op_q != exu_pkg::SYS_EBREAK);
  assign trap_we = first_q && is_sys && (sys_op_q == exu_pkg::SYS_ECALL);

  exu_csr_file csr_i (
    .clk        (clk),
    .rst        (rst),
    .raddr_i    (csr_addr),
    .rdata_o    (csr_rdata),
    .we_i       (csr_we),
    .waddr_i    (csr_addr),
    .wdata_i    (csr_wdata),
    .trap_we_i  (trap_we),
    .trap_epc_i (pc_q),
    .mtvec_o    (mtvec),
    .mepc_o     (mepc)
  );

  // the write lands after the first cycle, so later cycles use the saved value.
  always_ff @(posedge clk) begin
    if (first_q) begin
      csr_old_q <= csr_rdata;
    end
  end

  assign csr_old = first_q ? csr_rdata : csr_old_q;

  always_comb begin
    case (class_q)
      exu_pkg::CLS_LOAD:   wb_data_o = mem.rdata;
      exu_pkg::CLS_SYSTEM: wb_data_o = csr_old;
      exu_pkg::CLS_JUMP:   wb_data_o = pc_plus4;
      default:             wb_data_o = alu_res;
    endcase
  end

  assign ebreak_o = out_valid_o && is_sys && (sys_op_q == exu_pkg::SYS_EBREAK);

  assign mem.req   = (state == exu_pkg::EXU_BUSY);
  assign mem.we    = (class_q == exu_pkg::CLS_STORE);
  assign mem.addr  = target_q;
  assign mem.wdata = src2_q;

endmodule

`default_nettype wire

//--- exu/exu_mem_port.sv
`default_nettype none

module exu_mem_port (
  input  logic            clk,
  input  logic            rst,
  exu_mem_if.slave        mem,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output exu_pkg::word_t  mem_addr_o,
  output exu_pkg::word_t  mem_wdata_o,
  input  exu_pkg::word_t  mem_rdata_i,
  input  logic            mem_rvalid_i
);

  logic           req_q;
  logic           start;
  exu_pkg::word_t rdata_q;

  assign start = mem.req && !req_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_q     <= 1'b0;
      mem_req_o <= 1'b0;
    end else begin
      req_q <= mem.req;
      if (start) begin
        mem_req_o <= 1'b1;
      end else if (mem_rvalid_i) begin
        mem_req_o <= 1'b0;
      end
    end
  end

  // request fields stay put until the response.
  always_ff @(posedge clk) begin
    if (start) begin
      mem_we_o    <= mem.we;
      mem_addr_o  <= mem.addr;
      mem_wdata_o <= mem.wdata;
    end
    if (mem_req_o && mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem.done  = mem_req_o && mem_rvalid_i;
  assign mem.rdata = mem.done ? mem_rdata_i : rdata_q;

endmodule

`default_nettype wire

//--- verilog/exu_top.sv
`default_nettype none

module exu_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  exu_pkg::op_class_e  class_i,
  input  exu_pkg::alu_op_e    alu_op_i,
  input  exu_pkg::sys_op_e    sys_op_i,
  input  exu_pkg::word_t      src1_i,
  input  exu_pkg::word_t      src2_i,
  input  exu_pkg::word_t      target_i,
  input  exu_pkg::csr_addr_t  csr_addr_i,
  input  exu_pkg::reg_idx_t   rd_i,
  input  exu_pkg::word_t      pc_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                wb_en_o,
  output exu_pkg::reg_idx_t   rd_o,
  output exu_pkg::word_t      wb_data_o,
  output exu_pkg::word_t      npc_o,
  output logic                ebreak_o,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output exu_pkg::word_t      mem_addr_o,
  output exu_pkg::word_t      mem_wdata_o,
  input  exu_pkg::word_t      mem_rdata_i,
  input  logic                mem_rvalid_i
);

  exu_mem_if mem_bus ();

  exu_stage stage_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .class_i     (class_i),
    .alu_op_i    (alu_op_i),
    .sys_op_i    (sys_op_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .target_i    (target_i),
    .csr_addr_i  (csr_addr_i),
    .rd_i        (rd_i),
    .pc_i        (pc_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .wb_en_o     (wb_en_o),
    .rd_o        (rd_o),
    .wb_data_o   (wb_data_o),
    .npc_o       (npc_o),
    .ebreak_o    (ebreak_o),
    .mem         (mem_bus.master)
  );

  exu_mem_port mem_port_i (
    .clk          (clk),
    .rst          (rst),
    .mem          (mem_bus.slave),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i)
  );

endmodule

`default_nettype wire

//--- bench/exu_assert.sv
`default_nettype none

module exu_assert (
  input logic              clk,
  input logic              rst,
  input logic              in_ready_i,
  input logic              out_valid_i,
  input logic              out_ready_i,
  input logic              wb_en_i,
  input exu_pkg::reg_idx_t rd_i,
  input exu_pkg::word_t    wb_data_i,
  input exu_pkg::word_t    npc_i,
  input logic              ebreak_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  no_overlap: assert property (@(posedge clk) disable iff (rst)
    !(out_valid_i && in_ready_i))
    else begin
      $error("out_valid_o and in_ready_o high together");
      fail_count++;
    end

  wb_in_valid: assert property (@(posedge clk) disable iff (rst)
    wb_en_i |-> out_valid_i)
    else begin
      $error("wb_en_o high without out_valid_o");
      fail_count++;
    end

  // a stalled result keeps every output.
  hold_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && !wb_en_i && $stable(wb_data_i) &&
                                       $stable(npc_i) && $stable(rd_i) && $stable(ebreak_i)))
    else begin
      $error("outputs changed under back-pressure");
      fail_count++;
    end

  reset_state: assert property (@(posedge clk)
    rst |=> (in_ready_i && !out_valid_i && !wb_en_i && !ebreak_i))
    else begin
      $error("stage not idle after reset");
      fail_count++;
    end

endmodule

bind exu_stage exu_assert exu_assert_i (
  .clk         (clk),
  .rst         (rst),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .wb_en_i     (wb_en_o),
  .rd_i        (rd_o),
  .wb_data_i   (wb_data_o),
  .npc_i       (npc_o),
  .ebreak_i    (ebreak_o)
);

`default_nettype wire

//--- bench/exu_tb.sv
`default_nettype none

module exu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 50;

  logic                clk;
  logic                rst;
  logic                in_valid_i;
  logic                in_ready_o;
  exu_pkg::op_class_e  class_i;
  exu_pkg::alu_op_e    alu_op_i;
  exu_pkg::sys_op_e    sys_op_i;
  exu_pkg::word_t      src1_i;
  exu_pkg::word_t      src2_i;
  exu_pkg::word_t      target_i;
  exu_pkg::csr_addr_t  csr_addr_i;
  exu_pkg::reg_idx_t   rd_i;
  exu_pkg::word_t      pc_i;
  logic                out_valid_o;
  logic                out_ready_i;
  logic                wb_en_o;
  exu_pkg::reg_idx_t   rd_o;
  exu_pkg::word_t      wb_data_o;
  exu_pkg::word_t      npc_o;
  logic                ebreak_o;
  logic                mem_req_o;
  logic                mem_we_o;
  exu_pkg::word_t      mem_addr_o;
  exu_pkg::word_t      mem_wdata_o;
  exu_pkg::word_t      mem_rdata_i;
  logic                mem_rvalid_i;

  logic [31:0]         mem_model [64];
  logic                pending;
  int                  delay;
  logic                req_we;
  logic [31:0]         req_addr;
  logic [31:0]         req_wdata;

  int                  errors;
  int                  timeouts;
  int                  assert_fails;
  int                  wb_count = 0;
  logic [31:0]         got_wb;
  logic [31:0]         got_npc;
  logic                got_ebreak;
  exu_pkg::reg_idx_t   exp_rd;
  logic [31:0]         m_mtvec;
  logic [31:0]         m_mepc;

  exu_top exu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (wb_en_o === 1'b1) begin
      wb_count++;
    end
  end

  function automatic logic [31:0] fill_word(input int idx);
    return (idx + 1) * 32'h9e37_79b9;
  endfunction

  // memory answers after 1 to 5 cycles.
  initial begin
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    pending      = 1'b0;
    delay        = 0;
    for (int i = 0; i < 64; i++) begin
      mem_model[i] = fill_word(i);
    end
    forever begin
      @(negedge clk);
      if (mem_rvalid_i) begin
        mem_rvalid_i = 1'b0;
        pending      = 1'b0;
      end else if (pending) begin
        delay--;
        if (delay == 0) begin
          // request fields must not move while the request waits.
          check("mem_we_o", mem_we_o, req_we);
          check("mem_addr_o", mem_addr_o, req_addr);
          check("mem_wdata_o", mem_wdata_o, req_wdata);
          if (mem_we_o) begin
            mem_model[mem_addr_o[7:2]] = mem_wdata_o;
          end else begin
            mem_rdata_i = mem_model[mem_addr_o[7:2]];
          end
          mem_rvalid_i = 1'b1;
        end
      end else if (mem_req_o === 1'b1) begin
        pending   = 1'b1;
        delay     = 1 + $urandom % 5;
        req_we    = mem_we_o;
        req_addr  = mem_addr_o;
        req_wdata = mem_wdata_o;
      end
    end
  end

  function automatic logic [31:0] alu_ref(input exu_pkg::alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    case (op)
      exu_pkg::ALU_ADD:  return a + b;
      exu_pkg::ALU_SUB:  return a - b;
      exu_pkg::ALU_AND:  return a & b;
      exu_pkg::ALU_OR:   return a | b;
      exu_pkg::ALU_XOR:  return a ^ b;
      exu_pkg::ALU_SLL:  return a << b[4:0];
      exu_pkg::ALU_SRL:  return a >> b[4:0];
      exu_pkg::ALU_SRA:  return sa >>> b[4:0];
      exu_pkg::ALU_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SLE:  return (sa <= sb) ? 32'd1 : 32'd0;
      exu_pkg::ALU_SLEU: return (a <= b) ? 32'd1 : 32'd0;
      default:           return 32'd0;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (in_ready_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("%0t: stage did not return to idle within %0d cycles", $time, TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic wait_valid(output int n);
    n = 0;
    while (out_valid_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (out_valid_o !== 1'b1) begin
      $display("%0t: no result from the stage within %0d cycles", $time, TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic issue(input exu_pkg::op_class_e cls, input exu_pkg::alu_op_e aop,
                       input exu_pkg::sys_op_e sop, input logic [31:0] s1,
                       input logic [31:0] s2, input logic [31:0] tgt,
                       input exu_pkg::csr_addr_t csr, input logic [31:0] pc);
    wait_idle();
    exp_rd     = 5'($urandom);
    class_i    = cls;
    alu_op_i   = aop;
    sys_op_i   = sop;
    src1_i     = s1;
    src2_i     = s2;
    target_i   = tgt;
    csr_addr_i = csr;
    rd_i       = exp_rd;
    pc_i       = pc;
    in_valid_i = 1'b1;
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  task automatic exec(input exu_pkg::op_class_e cls, input exu_pkg::alu_op_e aop,
                      input exu_pkg::sys_op_e sop, input logic [31:0] s1,
                      input logic [31:0] s2, input logic [31:0] tgt,
                      input exu_pkg::csr_addr_t csr, input logic [31:0] pc);
    int n;
    issue(cls, aop, sop, s1, s2, tgt, csr, pc);
    wait_valid(n);
    got_wb     = wb_data_o;
    got_npc    = npc_o;
    got_ebreak = ebreak_o;
    check("wb_en_o", wb_en_o, 1'b1);
    check("rd_o", rd_o, exp_rd);
    if (cls != exu_pkg::CLS_LOAD && cls != exu_pkg::CLS_STORE) begin
      check("out_valid_o latency", n, 0);
    end
    wait_idle();
  endtask

  task automatic read_csr(input exu_pkg::csr_addr_t addr, input logic [31:0] exp);
    exec(exu_pkg::CLS_SYSTEM, exu_pkg::ALU_ADD, exu_pkg::SYS_CSRRS, 32'd0, 32'd0, 32'd0,
         addr, 32'h0000_0300);
    check("wb_data_o", got_wb, exp);
  endtask

  task automatic test_alu();
    exu_pkg::alu_op_e op;
    logic [31:0]      a;
    logic [31:0]      b;
    int               c0;
    for (int i = 0; i < 20; i++) begin
      // every operation once, then the compares twice more.
      if (i < 12) begin
        op = exu_pkg::alu_op_e'(4'(i));
      end else begin
        op = exu_pkg::alu_op_e'(4'(8 + i % 4));
      end
      a  = $urandom;
      b  = $urandom;
      // equal operands reach the compares in the last pass.
      if (i >= 16) begin
        b = a;
      end
      c0 = wb_count;
      exec(exu_pkg::CLS_ALU, op, exu_pkg::SYS_CSRRW, a, b, 32'd0, 12'd0, 32'h0000_0200);
      check("wb_data_o", got_wb, alu_ref(op, a, b));
      check("wb_en_o pulses", wb_count - c0, 1);
      check("ebreak_o", got_ebreak, 1'b0);
      check("npc_o", got_npc, 32'h0000_0204);
    end
  endtask

  task automatic branch_case(input exu_pkg::alu_op_e op, input logic [31:0] a,
                             input logic [31:0] b, input logic exp_taken);
    logic [31:0] pc;
    logic [31:0] tgt;
    pc  = $urandom & ~32'h3;
    tgt = $urandom & ~32'h3;
    exec(exu_pkg::CLS_BRANCH, op, exu_pkg::SYS_CSRRW, a, b, tgt, 12'd0, pc);
    check("npc_o", got_npc, exp_taken ? tgt : pc + 32'd4);
  endtask

  task automatic test_branch();
    logic [31:0] pc;
    logic [31:0] tgt;
    branch_case(exu_pkg::ALU_SUB, 32'd7, 32'd7, 1'b1);
    branch_case(exu_pkg::ALU_SUB, 32'd7, 32'd8, 1'b0);
    branch_case(exu_pkg::ALU_XOR, 32'h55, 32'h54, 1'b1);
    branch_case(exu_pkg::ALU_XOR, 32'h55, 32'h55, 1'b0);
    branch_case(exu_pkg::ALU_SLT, 32'hffff_fffb, 32'd3, 1'b1);
    branch_case(exu_pkg::ALU_SLT, 32'd3, 32'hffff_fffb, 1'b0);
    branch_case(exu_pkg::ALU_SLTU, 32'd3, 32'hffff_fffb, 1'b1);
    branch_case(exu_pkg::ALU_SLTU, 32'hffff_fffb, 32'd3, 1'b0);
    branch_case(exu_pkg::ALU_SLE, 32'h8000_0000, 32'h8000_0000, 1'b1);
    branch_case(exu_pkg::ALU_SLE, 32'd1, 32'hffff_ffff, 1'b0);
    branch_case(exu_pkg::ALU_SLEU, 32'd9, 32'd9, 1'b1);
    branch_case(exu_pkg::ALU_SLEU, 32'hffff_ffff, 32'd1, 1'b0);
    repeat (3) begin
      pc  = $urandom & ~32'h3;
      tgt = $urandom & ~32'h3;
      exec(exu_pkg::CLS_JUMP, exu_pkg::ALU_ADD, exu_pkg::SYS_CSRRW, 32'd0, 32'd0, tgt,
           12'd0, pc);
      check("npc_o", got_npc, tgt);
      check("wb_data_o", got_wb, pc + 32'd4);
    end
  endtask

  task automatic test_memory();
    int          base;
    int          idx [8];
    logic [31:0] data [8];
    base = $urandom % 64;
    for (int k = 0; k < 8; k++) begin
      idx[k]  = (base + k * 7) % 64;
      data[k] = $urandom;
      exec(exu_pkg::CLS_STORE, exu_pkg::ALU_ADD, exu_pkg::SYS_CSRRW, 32'd0, data[k],
           idx[k] * 4, 12'd0, 32'h0000_0400);
      check("mem_we_o", req_we, 1'b1);
      check("mem_addr_o", req_addr, idx[k] * 4);
      check("mem_wdata_o", req_wdata, data[k]);
    end
    for (int k = 0; k < 8; k++) begin
      exec(exu_pkg::CLS_LOAD, exu_pkg::ALU_ADD, exu_pkg::SYS_CSRRW, 32'd0, 32'd0,
           idx[k] * 4, 12'd0, 32'h0000_0400);
      check("mem_we_o", req_we, 1'b0);
      check("mem_addr_o", req_addr, idx[k] * 4);
      check("wb_data_o", got_wb, data[k]);
    end
    // a word no store touched.
    exec(exu_pkg::CLS_LOAD, exu_pkg::ALU_ADD, exu_pkg::SYS_CSRRW, 32'd0, 32'd0,
         ((base + 60) % 64) * 4, 12'd0, 32'h0000_0400);
    check("wb_data_o", got_wb, fill_word((base + 60) % 64));
  endtask

  task automatic test_csr();
    exu_pkg::sys_op_e   sop;
    exu_pkg::csr_addr_t addr;
    logic [31:0]        src;
    logic [31:0]        old;
    logic [31:0]        nxt;
    for (int r = 0; r < 2; r++) begin
      addr = (r == 0) ? exu_pkg::CSR_MTVEC : exu_pkg::CSR_MEPC;
      for (int k = 0; k < 6; k++) begin
        sop = exu_pkg::sys_op_e'(4'(k));
        src = $urandom;
        if (sop == exu_pkg::SYS_CSRRWI || sop == exu_pkg::SYS_CSRRSI ||
            sop == exu_pkg::SYS_CSRRCI) begin
          src = src & 32'h1f;
        end
        old = (r == 0) ? m_mtvec : m_mepc;
        exec(exu_pkg::CLS_SYSTEM, exu_pkg::ALU_ADD, sop, src, 32'd0, 32'd0, addr,
             32'h0000_0300);
        check("wb_data_o", got_wb, old);
        case (sop)
          exu_pkg::SYS_CSRRS, exu_pkg::SYS_CSRRSI: nxt = old | src;
          exu_pkg::SYS_CSRRC, exu_pkg::SYS_CSRRCI: nxt = old & ~src;
          default:                                 nxt = src;
        endcase
        if (r == 0) begin
          m_mtvec = nxt;
        end else begin
          m_mepc = nxt;
        end
        read_csr(addr, nxt);
      end
    end
  endtask

  task automatic test_trap();
    logic [31:0] pc;
    logic [31:0] ms;
    m_mtvec = ($urandom & 32'h0000_fffc) | 32'h0000_0100;
    exec(exu_pkg::CLS_SYSTEM, exu_pkg::ALU_ADD, exu_pkg::SYS_CSRRW, m_mtvec, 32'd0, 32'd0,
         exu_pkg::CSR_MTVEC, 32'h0000_0300);
    pc = $urandom & ~32'h3;
    exec(exu_pkg::CLS_SYSTEM, exu_pkg::ALU_ADD, exu_pkg::SYS_ECALL, 32'd0, 32'd0, 32'd0,
         12'd0, pc);
    check("npc_o", got_npc, m_mtvec);
    m_mepc = pc;
    read_csr(exu_pkg::CSR_MEPC, m_mepc);
    read_csr(exu_pkg::CSR_MCAUSE, 32'd11);
    // mie set and mpie clear before the return.
    ms = 32'h0000_1808;
    exec(exu_pkg::CLS_SYSTEM, exu_pkg::ALU_ADD, exu_pkg::SYS_CSRRW, ms, 32'd0, 32'd0,
         exu_pkg::CSR_MSTATUS, 32'h0000_0300);
    exec(exu_pkg::CLS_SYSTEM, exu_pkg::ALU_ADD, exu_pkg::SYS_MRET, 32'd0, 32'd0, 32'd0,
         12'd0, m_mtvec);
    check("npc_o", got_npc, m_mepc);
    read_csr(exu_pkg::CSR_MSTATUS, (ms & ~32'h88) | 32'h80 | ((ms >> 4) & 32'h8));
    exec(exu_pkg::CLS_SYSTEM, exu_pkg::ALU_ADD, exu_pkg::SYS_EBREAK, 32'd0, 32'd0, 32'd0,
         12'd0, 32'h0000_0500);
    check("ebreak_o", got_ebreak, 1'b1);
    check("ebreak_o", ebreak_o, 1'b0);
  endtask

  task automatic test_backpressure();
    int          n;
    int          c0;
    int          hold;
    logic [31:0] val;
    val         = $urandom & ~32'h3;
    c0          = wb_count;
    out_ready_i = 1'b0;
    issue(exu_pkg::CLS_SYSTEM, exu_pkg::ALU_ADD, exu_pkg::SYS_CSRRW, val, 32'd0, 32'd0,
          exu_pkg::CSR_MEPC, 32'h0000_0600);
    wait_valid(n);
    got_wb  = wb_data_o;
    got_npc = npc_o;
    check("wb_data_o", got_wb, m_mepc);
    hold = 2 + $urandom % 6;
    repeat (hold) begin
      @(negedge clk);
      check("out_valid_o", out_valid_o, 1'b1);
      check("in_ready_o", in_ready_o, 1'b0);
      check("wb_en_o", wb_en_o, 1'b0);
      check("wb_data_o", wb_data_o, got_wb);
      check("npc_o", npc_o, got_npc);
      check("rd_o", rd_o, exp_rd);
    end
    out_ready_i = 1'b1;
    wait_idle();
    check("wb_en_o pulses", wb_count - c0, 1);
    m_mepc = val;
    read_csr(exu_pkg::CSR_MEPC, m_mepc);
  endtask

  initial begin
    errors      = 0;
    timeouts    = 0;
    void'($urandom(72));
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    class_i     = exu_pkg::CLS_ALU;
    alu_op_i    = exu_pkg::ALU_ADD;
    sys_op_i    = exu_pkg::SYS_CSRRW;
    src1_i      = '0;
    src2_i      = '0;
    target_i    = '0;
    csr_addr_i  = '0;
    rd_i        = '0;
    pc_i        = '0;
    m_mtvec     = exu_pkg::MTVEC_RESET;
    m_mepc      = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("in_ready_o", in_ready_o, 1'b1);
    check("out_valid_o", out_valid_o, 1'b0);
    check("wb_en_o", wb_en_o, 1'b0);
    check("mem_req_o", mem_req_o, 1'b0);
    check("ebreak_o", ebreak_o, 1'b0);
    read_csr(exu_pkg::CSR_MSTATUS, exu_pkg::MSTATUS_RESET);
    test_alu();
    test_branch();
    test_memory();
    test_csr();
    test_trap();
    test_backpressure();
    repeat (2) @(negedge clk);
    assert_fails = exu_top_i.stage_i.exu_assert_i.fail_count;
    $display("check errors: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
common/exu_pkg.sv
common/exu_mem_if.sv
verilog/exu_alu.sv
exu/exu_csr_file.sv
exu/exu_stage.sv
exu/exu_mem_port.sv
verilog/exu_top.sv
bench/exu_assert.sv
bench/exu_tb.sv

//--- Bender.yml
package:
  name: exu

sources:
  - common/exu_pkg.sv
  - common/exu_mem_if.sv
  - verilog/exu_alu.sv
  - exu/exu_csr_file.sv
  - exu/exu_stage.sv
  - exu/exu_mem_port.sv
  - verilog/exu_top.sv
  - target: test
    files:
      - bench/exu_assert.sv
      - bench/exu_tb.sv
